/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the vertical filter testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_vertical_filter
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f sim.f \
  --top-module "$TOP" \
  -Mdir "$BUILD_DIR" \
  -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
  echo "Simulation ended without a result line, see $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

/* sim.f */
verilog/window_pkg.sv
verilog/frame_flush.sv
verilog/line_delay.sv
verilog/row_window_buffer.sv
verilog/column_sum.sv
verilog/vertical_filter.sv
verification/tb_vertical_filter.sv

/* verification/tb_vertical_filter.sv */
`timescale 1ns/1ps

module tb_vertical_filter;

  import window_pkg::*;

  localparam int PH_RESET  = 10;
  localparam int PH_IDLE   = 2;
  localparam int PH_RANDOM = 600;
  localparam int PH_ZERO   = 221;  // Clears thirteen rows of history
  localparam int PH_CONST  = 240;
  localparam int PH_SINGLE = 240;
  localparam int PH_DOUBLE = 260;
  localparam int PH_ONES   = 240;
  localparam int MARGIN    = 300;
  localparam int TIMEOUT   = PH_RESET + PH_IDLE + PH_RANDOM + PH_ZERO + PH_CONST
                           + PH_SINGLE + PH_DOUBLE + PH_ONES + MARGIN;
  localparam int MAX_EDGES = TIMEOUT + 16;

  localparam int CHAIN_LAT = NUM_LINES * ROW_WIDTH;  // 204
  localparam int DONE_LAT  = CHAIN_LAT + 2;          // done_i to done_o
  localparam int STRETCH   = ROW_WIDTH + 1;          // Flush length after done_i
  localparam int PULSE_GAP = 8;

  logic   clk;
  logic   rst_n;
  pixel_t pixel_i;
  logic   done_i;
  sum_t   sum_o;
  logic   done_o;

  integer seed;
  int     err_cnt;
  int     check_cnt;
  int     edge_cnt;
  int     cycle_cnt;

  // What the DUT sampled at each rising edge
  pixel_t pix_hist  [MAX_EDGES];
  logic   done_hist [MAX_EDGES];
  logic   rst_hist  [MAX_EDGES];

  vertical_filter i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .pixel_i(pixel_i),
    .done_i (done_i),
    .sum_o  (sum_o),
    .done_o (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("TESTS FAILED");
    $finish;
  end

  always @(posedge clk) begin
    if (edge_cnt < MAX_EDGES) begin
      rst_hist[edge_cnt]  = rst_n;
      pix_hist[edge_cnt]  = rst_n ? pixel_i : '0;  // Reset clears the chain
      done_hist[edge_cnt] = rst_n & done_i;
    end
    edge_cnt++;
  end

  // Expected sum_o just after edge m
  function automatic sum_t expected_sum(input int m);
    int acc;
    int n;
    acc = 0;
    if (rst_hist[m]) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        n = m - 1 - k * ROW_WIDTH;
        if (n >= 0) begin
          acc = acc + int'(pix_hist[n]);
        end
      end
    end
    return sum_t'(acc);
  endfunction

  // done_i or the flush that follows it, as seen by the first row delay
  function automatic logic stretched_done(input int n);
    logic hit;
    hit = 1'b0;
    if (n >= 0 && rst_hist[n]) begin
      hit = done_hist[n];
      for (int j = 1; j <= STRETCH; j++) begin
        if (n - j >= 0 && done_hist[n-j]) begin
          hit = 1'b1;
        end
      end
    end
    return hit;
  endfunction

  function automatic logic expected_done(input int m);
    logic res;
    res = 1'b0;
    if (rst_hist[m]) begin
      res = stretched_done(m - 1 - CHAIN_LAT);
    end
    return res;
  endfunction

  // Compare against the model between edges
  always @(negedge clk) begin
    sum_t exp_sum;
    logic exp_done;
    if (edge_cnt > 0 && edge_cnt <= MAX_EDGES) begin
      exp_sum  = expected_sum(edge_cnt - 1);
      exp_done = expected_done(edge_cnt - 1);
      check_cnt += 2;
      assert (sum_o == exp_sum) else begin
        err_cnt++;
        $display("error: sum_o got %h expected %h at edge %0d", sum_o, exp_sum, edge_cnt - 1);
      end
      assert (done_o == exp_done) else begin
        err_cnt++;
        $display("error: done_o got %h expected %h at edge %0d", done_o, exp_done,
                 edge_cnt - 1);
      end
    end
  end

  task automatic drive_cycle(input pixel_t pix, input logic done);
    @(posedge clk);
    pixel_i <= pix;
    done_i  <= done;
  endtask

  task automatic random_pixels(input int len);
    logic [31:0] rnd;
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      drive_cycle(rnd[7:0], 1'b0);
    end
  endtask

  task automatic const_pixels(input pixel_t pix, input int len);
    for (int i = 0; i < len; i++) begin
      drive_cycle(pix, 1'b0);
    end
  endtask

  task automatic check_idle_after_reset();
    logic [31:0] rnd;
    for (int i = 0; i < PH_IDLE; i++) begin
      rnd = $random(seed);
      drive_cycle(rnd[7:0], 1'b0);
      @(negedge clk);
      check_cnt++;
      assert (sum_o == '0 && done_o == 1'b0) else begin
        err_cnt++;
        $display("error: sum_o got %h done_o got %h expected 0 right after reset",
                 sum_o, done_o);
      end
    end
  endtask

  // Sum climbs one row at a time over a zero history
  task automatic const_growth(input pixel_t pix, input int len);
    int   rows;
    sum_t exp_sum;
    for (int i = 0; i < len; i++) begin
      drive_cycle(pix, 1'b0);
      @(negedge clk);
      rows = (i < 2) ? 0 : (i - 2) / ROW_WIDTH + 1;
      if (rows > NUM_TAPS) begin
        rows = NUM_TAPS;
      end
      exp_sum = sum_t'(int'(pix) * rows);
      check_cnt++;
      assert (sum_o == exp_sum) else begin
        err_cnt++;
        $display("error: sum_o got %h expected %h in constant phase step %0d",
                 sum_o, exp_sum, i);
      end
    end
  endtask

  // One pulse, or two when gap is nonzero
  task automatic done_phase(input int len, input int gap, input int exp_high);
    logic [31:0] rnd;
    logic        pulse;
    int          first_hi;
    int          hi_cnt;
    first_hi = -1;
    hi_cnt   = 0;
    for (int i = 0; i < len; i++) begin
      rnd   = $random(seed);
      pulse = (i == 0) || (gap > 0 && i == gap);
      drive_cycle(rnd[7:0], pulse);
      @(negedge clk);
      if (done_o) begin
        if (first_hi < 0) begin
          first_hi = i;
        end
        hi_cnt++;
      end
    end
    check_cnt += 2;
    assert (first_hi == DONE_LAT) else begin
      err_cnt++;
      $display("done_o rose %0d cycles after done_i instead of %0d", first_hi, DONE_LAT);
    end
    assert (hi_cnt == exp_high) else begin
      err_cnt++;
      $display("done_o was high for %0d cycles instead of %0d", hi_cnt, exp_high);
    end
  endtask

  initial begin
    seed      = 88957;
    err_cnt   = 0;
    check_cnt = 0;
    edge_cnt  = 0;
    rst_n     = 1'b0;
    pixel_i   = '0;
    done_i    = 1'b0;

    repeat (PH_RESET) @(posedge clk);
    rst_n <= 1'b1;

    check_idle_after_reset();
    random_pixels(PH_RANDOM);
    const_pixels('0, PH_ZERO);
    const_growth(8'h5a, PH_CONST);
    done_phase(PH_SINGLE, 0, ROW_WIDTH + 2);
    done_phase(PH_DOUBLE, PULSE_GAP, PULSE_GAP + ROW_WIDTH + 2);

    const_pixels(8'hff, PH_ONES);
    @(negedge clk);
    check_cnt++;
    assert (sum_o == sum_t'(NUM_TAPS * 255)) else begin
      err_cnt++;
      $display("error: sum_o got %h expected %h after all-ones phase", sum_o,
               sum_t'(NUM_TAPS * 255));
    end
    @(posedge clk);  // Let the last model check finish

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* verilog/column_sum.sv */
`timescale 1ns/1ps

module column_sum (
  input  logic                clk,
  input  logic                rst_n,
  input  window_pkg::window_t window_i,
  output window_pkg::sum_t    sum_o,
  output logic                done_o
);

  import window_pkg::*;

  sum_t part_lo;
  sum_t part_hi;
  sum_t part_lo_q;
  sum_t part_hi_q;
  logic done_q;

  // Partial sums over the upper and lower halves of the column
  always_comb begin
    part_lo = '0;
    part_hi = '0;
    for (int k = 0; k < SPLIT_TAP; k++) begin
      part_lo = part_lo + sum_t'(window_i.taps[k]);
    end
    for (int k = SPLIT_TAP; k < NUM_TAPS; k++) begin
      part_hi = part_hi + sum_t'(window_i.taps[k]);
    end
  end

  // Stage one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      part_lo_q <= '0;
      part_hi_q <= '0;
      done_q    <= 1'b0;
    end else begin
      part_lo_q <= part_lo;
      part_hi_q <= part_hi;
      done_q    <= window_i.done;
    end
  end

  // Stage two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_o  <= '0;
      done_o <= 1'b0;
    end else begin
      sum_o  <= part_lo_q + part_hi_q;
      done_o <= done_q;
    end
  end

  // Thirteen full-scale pixels still fit
  a_sum_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_o <= SUM_MAX
  ) else $error("column sum out of range: %h", sum_o);

  // A full-scale column lands two cycles later as the maximum sum
  a_full_scale: assert property (
    @(posedge clk) disable iff (!rst_n)
    (window_i.taps == {NUM_TAPS{PIXEL_MAX}}) |-> ##2 (sum_o == SUM_MAX)
  ) else $error("full-scale column did not sum to %h", SUM_MAX);

endmodule

/* verilog/frame_flush.sv */
`timescale 1ns/1ps

module frame_flush (
  input  logic clk,
  input  logic rst_n,
  input  logic done_i,
  output logic flush_o
);

  import window_pkg::*;

  flush_cnt_t cnt_q;
  logic       flush_q;

  // Holds flush high for ROW_WIDTH+1 cycles after the last done_i
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      flush_q <= 1'b0;
    end else if (done_i) begin
      cnt_q   <= '0;  // Restart the stretch
      flush_q <= 1'b1;
    end else if (flush_q && (cnt_q < FLUSH_LAST)) begin
      cnt_q   <= cnt_q + 1'b1;
      flush_q <= 1'b1;
    end else begin
      cnt_q   <= '0;
      flush_q <= 1'b0;
    end
  end

  assign flush_o = flush_q;

  // Counter stays inside the row length
  a_cnt_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    cnt_q <= FLUSH_LAST
  ) else $error("frame_flush counter out of range: %0d", cnt_q);

endmodule

/* verilog/line_delay.sv */
`timescale 1ns/1ps

module line_delay #(
  parameter int DEPTH = window_pkg::ROW_WIDTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  window_pkg::pixel_t data_i,
  input  logic               done_i,
  output window_pkg::pixel_t data_o,
  output logic               done_o
);

  import window_pkg::*;

  pixel_t             pix_q [DEPTH];
  logic   [DEPTH-1:0] done_q;
  logic   [DEPTH-1:0] primed_q;  // Fills with ones as post-reset history builds up

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        pix_q[i] <= '0;
      end
      done_q   <= '0;
      primed_q <= '0;
    end else begin
      pix_q[0]    <= data_i;
      done_q[0]   <= done_i;
      primed_q[0] <= 1'b1;
      for (int i = 1; i < DEPTH; i++) begin
        pix_q[i]    <= pix_q[i-1];
        done_q[i]   <= done_q[i-1];
        primed_q[i] <= primed_q[i-1];
      end
    end
  end

  assign data_o = pix_q[DEPTH-1];
  assign done_o = done_q[DEPTH-1];

  // Exact DEPTH-cycle delay once every slot holds post-reset data
  a_delay_exact: assert property (
    @(posedge clk) disable iff (!rst_n)
    primed_q[DEPTH-1] |->
      (data_o == $past(data_i, DEPTH)) && (done_o == $past(done_i, DEPTH))
  ) else $error("line_delay output does not match input from %0d cycles back", DEPTH);

endmodule

/* verilog/row_window_buffer.sv */
`timescale 1ns/1ps

module row_window_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  window_pkg::pixel_t  pixel_i,
  input  logic                done_i,
  output window_pkg::window_t window_o
);

  import window_pkg::*;

  logic               flush;
  pixel_t             chain_pix [NUM_LINES+1];  // Index 0 is the live pixel
  logic [NUM_LINES:0] chain_done;

  frame_flush i_frame_flush (
    .clk    (clk),
    .rst_n  (rst_n),
    .done_i (done_i),
    .flush_o(flush)
  );

  assign chain_pix[0]  = pixel_i;
  assign chain_done[0] = done_i | flush;  // Stretched end-of-frame

  for (genvar k = 0; k < NUM_LINES; k++) begin : gen_lines
    line_delay #(
      .DEPTH(ROW_WIDTH)
    ) i_line_delay (
      .clk    (clk),
      .rst_n  (rst_n),
      .data_i (chain_pix[k]),
      .done_i (chain_done[k]),
      .data_o (chain_pix[k+1]),
      .done_o (chain_done[k+1])
    );
  end

  // Pack the column into the window
  always_comb begin
    window_o.done = chain_done[NUM_LINES];
    for (int k = 0; k < NUM_TAPS; k++) begin
      window_o.taps[k] = chain_pix[k];
    end
  end

  // Flush ends ROW_WIDTH+2 cycles after the last done_i
  a_flush_length: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(flush) |-> $past(done_i, ROW_WIDTH + 2)
  ) else $error("flush did not end ROW_WIDTH+2 cycles after the last done_i");

  // Done leaves the chain NUM_LINES rows after it entered
  a_chain_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    $past(rst_n, NUM_LINES * ROW_WIDTH) |->
      (window_o.done == $past(chain_done[0], NUM_LINES * ROW_WIDTH))
  ) else $error("window done is misaligned with the chain input");

endmodule

/* verilog/vertical_filter.sv */
`timescale 1ns/1ps

module vertical_filter (
  input  logic               clk,
  input  logic               rst_n,
  input  window_pkg::pixel_t pixel_i,
  input  logic               done_i,
  output window_pkg::sum_t   sum_o,
  output logic               done_o
);

  import window_pkg::*;

  window_t window;  // Thirteen aligned taps plus done

  row_window_buffer i_row_window_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .pixel_i (pixel_i),
    .done_i  (done_i),
    .window_o(window)
  );

  column_sum i_column_sum (
    .clk     (clk),
    .rst_n   (rst_n),
    .window_i(window),
    .sum_o   (sum_o),
    .done_o  (done_o)
  );

endmodule

/* verilog/window_pkg.sv */
package window_pkg;

  // Frame geometry
  localparam int ROW_WIDTH = 17;
  localparam int NUM_LINES = 12;
  localparam int NUM_TAPS  = NUM_LINES + 1;

  localparam int PIXEL_W = 8;
  localparam int SUM_W   = 12;

  // Column sum splits into taps 0..6 and 7..12
  localparam int SPLIT_TAP = 7;

  localparam int FLUSH_CNT_W = $clog2(ROW_WIDTH + 1);

  typedef logic [PIXEL_W-1:0]     pixel_t;
  typedef logic [SUM_W-1:0]       sum_t;
  typedef logic [FLUSH_CNT_W-1:0] flush_cnt_t;

  localparam pixel_t     PIXEL_MAX  = '1;
  localparam sum_t       SUM_MAX    = sum_t'(NUM_TAPS * 255);  // 3315
  localparam flush_cnt_t FLUSH_LAST = flush_cnt_t'(ROW_WIDTH);

  // Tap 0 is the live pixel, tap k is k rows up
  typedef struct packed {
    pixel_t [NUM_TAPS-1:0] taps;
    logic                  done;
  } window_t;

endpackage
